//--- hw/bootrom.sv
/* Read-only boot table, tagged word index per entry,
   with an error response for writes */

`timescale 1ns/1ns

module bootrom (
   input  logic              clk,
   input  logic              reset_i,
   input  tile_pkg::wb_req_t req_i,
   output tile_pkg::wb_rsp_t rsp_o
);

   localparam int KW = $clog2(tile_pkg::BOOT_WORDS);
   localparam int HALF_W = tile_pkg::DATA_W / 2;

   logic [KW-1:0]               word_k;
   logic [tile_pkg::DATA_W-1:0] dat_q;
   logic                        ack_q;
   logic                        err_q;
   logic                        access;

   assign word_k = req_i.adr[2 +: KW];             // Bits 5:2
   assign access = req_i.cyc & req_i.stb & ~(ack_q | err_q);

   always_ff @(posedge clk) begin
      if (access && !req_i.we) begin
         dat_q <= {tile_pkg::BOOT_TAG, HALF_W'(word_k)};
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= access & ~req_i.we;
         err_q <= access & req_i.we;               // ROM is not writable
      end
   end

   assign rsp_o.dat = dat_q;
   assign rsp_o.ack = ack_q;
   assign rsp_o.err = err_q;

endmodule

//--- hw/compute_tile_dm.sv
/* Compute tile local bus: arbiter, address decoder,
   local data memory and boot ROM */

`timescale 1ns/1ns

module compute_tile_dm #(
   parameter int NUM_MASTERS = 3,
   parameter int LMEM_WORDS  = 256
) (
   input  logic                                clk,
   input  logic                                reset_i,
   input  tile_pkg::wb_req_t [NUM_MASTERS-1:0] m_req_i,
   output tile_pkg::wb_rsp_t [NUM_MASTERS-1:0] m_rsp_o
);

   tile_pkg::wb_req_t bus_req;     // Granted master's request
   tile_pkg::wb_rsp_t bus_rsp;
   tile_pkg::wb_req_t dm_req;
   tile_pkg::wb_rsp_t dm_rsp;
   tile_pkg::wb_req_t boot_req;
   tile_pkg::wb_rsp_t boot_rsp;

   wb_bus_arbiter #(
      .NUM_MASTERS (NUM_MASTERS)
   ) u_arbiter (
      .clk       (clk),
      .reset_i   (reset_i),
      .m_req_i   (m_req_i),
      .m_rsp_o   (m_rsp_o),
      .bus_req_o (bus_req),
      .bus_rsp_i (bus_rsp)
   );

   wb_bus_decode u_decode (
      .bus_req_i  (bus_req),
      .bus_rsp_o  (bus_rsp),
      .dm_req_o   (dm_req),
      .dm_rsp_i   (dm_rsp),
      .boot_req_o (boot_req),
      .boot_rsp_i (boot_rsp)
   );

   // Region 0
   wb_sram_sp #(
      .LMEM_WORDS (LMEM_WORDS)
   ) u_ram (
      .clk     (clk),
      .reset_i (reset_i),
      .req_i   (dm_req),
      .rsp_o   (dm_rsp)
   );

   // Region f
   bootrom u_bootrom (
      .clk     (clk),
      .reset_i (reset_i),
      .req_i   (boot_req),
      .rsp_o   (boot_rsp)
   );

endmodule

//--- hw/tile_pkg.sv
/* Shared bus widths, region codes, request and response structs,
   and the enums for slave choice and arbiter state */

package tile_pkg;

   localparam int ADDR_W = 32;                   // Bus address width
   localparam int DATA_W = 32;                   // Bus data width
   localparam int SEL_W  = DATA_W / 8;           // One select bit per byte lane

   // Address bits 31:28 pick the slave
   localparam logic [3:0] REGION_DM   = 4'h0;    // Local data memory
   localparam logic [3:0] REGION_BOOT = 4'hf;    // Boot ROM

   localparam int BOOT_WORDS = 16;               // Boot ROM depth
   localparam logic [15:0] BOOT_TAG = 16'hb007;  // Upper half of each ROM word

   // One master's request on the classic bus
   typedef struct packed {
      logic [ADDR_W-1:0] adr;
      logic [DATA_W-1:0] dat;
      logic [SEL_W-1:0]  sel;
      logic              we;
      logic              cyc;
      logic              stb;
   } wb_req_t;

   // Slave or bus response
   typedef struct packed {
      logic [DATA_W-1:0] dat;
      logic              ack;
      logic              err;
   } wb_rsp_t;

   // Decoder target
   typedef enum logic [1:0] {
      SLAVE_DM,
      SLAVE_BOOT,
      SLAVE_NONE
   } slave_e;

   // Arbiter FSM
   typedef enum logic {
      ARB_IDLE,
      ARB_BUSY
   } arb_state_e;

endpackage

//--- hw/wb_bus_arbiter.sv
/* Round-robin arbiter that grants the shared bus to one master
   and returns the bus response to the granted master only */

`timescale 1ns/1ns

module wb_bus_arbiter #(
   parameter int NUM_MASTERS = 3
) (
   input  logic                                  clk,
   input  logic                                  reset_i,
   input  tile_pkg::wb_req_t [NUM_MASTERS-1:0]   m_req_i,
   output tile_pkg::wb_rsp_t [NUM_MASTERS-1:0]   m_rsp_o,
   output tile_pkg::wb_req_t                     bus_req_o,
   input  tile_pkg::wb_rsp_t                     bus_rsp_i
);

   localparam int IDX_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

   tile_pkg::arb_state_e state;
   logic [IDX_W-1:0]     grant_idx;    // Master that owns the bus
   logic [IDX_W-1:0]     last_idx;     // Previous owner, search starts after it
   logic [IDX_W-1:0]     next_idx;
   logic                 req_any;
   int                   cand;

   // Search from the master after the last owner
   always_comb begin
      next_idx = last_idx;
      req_any  = 1'b0;
      cand     = 0;
      for (int i = 1; i <= NUM_MASTERS; i++) begin
         cand = (int'(last_idx) + i) % NUM_MASTERS;
         if (!req_any && m_req_i[cand].cyc) begin
            req_any  = 1'b1;
            next_idx = IDX_W'(cand);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state     <= tile_pkg::ARB_IDLE;
         grant_idx <= '0;
         last_idx  <= IDX_W'(NUM_MASTERS - 1);   // Master 0 wins first
      end else begin
         case (state)
            tile_pkg::ARB_IDLE: begin
               if (req_any) begin
                  grant_idx <= next_idx;
                  state     <= tile_pkg::ARB_BUSY;
               end
            end
            tile_pkg::ARB_BUSY: begin
               if (!m_req_i[grant_idx].cyc) begin
                  last_idx <= grant_idx;           // Owner released the bus
                  state    <= tile_pkg::ARB_IDLE;
               end
            end
            default: state <= tile_pkg::ARB_IDLE;
         endcase
      end
   end

   always_comb begin
      bus_req_o = '0;                              // Idle bus carries no cycle
      if (state == tile_pkg::ARB_BUSY) begin
         bus_req_o = m_req_i[grant_idx];
      end
   end

   for (genvar m = 0; m < NUM_MASTERS; m++) begin : gen_rsp
      assign m_rsp_o[m] = (state == tile_pkg::ARB_BUSY && grant_idx == IDX_W'(m)) ?
                          bus_rsp_i : '0;
   end

endmodule

//--- hw/wb_bus_decode.sv
/* Address decoder that routes the bus request to the local memory
   or the boot ROM and answers unmapped addresses with an error */

`timescale 1ns/1ns

module wb_bus_decode (
   input  tile_pkg::wb_req_t bus_req_i,
   output tile_pkg::wb_rsp_t bus_rsp_o,
   output tile_pkg::wb_req_t dm_req_o,
   input  tile_pkg::wb_rsp_t dm_rsp_i,
   output tile_pkg::wb_req_t boot_req_o,
   input  tile_pkg::wb_rsp_t boot_rsp_i
);

   tile_pkg::slave_e target;
   logic [3:0]       region;
   logic             active;

   assign region = bus_req_i.adr[tile_pkg::ADDR_W-1 -: 4];    // Bits 31:28
   assign active = bus_req_i.cyc & bus_req_i.stb;

   always_comb begin
      case (region)
         tile_pkg::REGION_DM:   target = tile_pkg::SLAVE_DM;
         tile_pkg::REGION_BOOT: target = tile_pkg::SLAVE_BOOT;
         default:               target = tile_pkg::SLAVE_NONE;
      endcase
   end

   // Address, data and select fan out; only the target sees cyc and stb
   always_comb begin
      dm_req_o       = bus_req_i;
      dm_req_o.cyc   = bus_req_i.cyc & (target == tile_pkg::SLAVE_DM);
      dm_req_o.stb   = bus_req_i.stb & (target == tile_pkg::SLAVE_DM);

      boot_req_o     = bus_req_i;
      boot_req_o.cyc = bus_req_i.cyc & (target == tile_pkg::SLAVE_BOOT);
      boot_req_o.stb = bus_req_i.stb & (target == tile_pkg::SLAVE_BOOT);
   end

   always_comb begin
      case (target)
         tile_pkg::SLAVE_DM: begin
            bus_rsp_o = dm_rsp_i;
         end
         tile_pkg::SLAVE_BOOT: begin
            bus_rsp_o = boot_rsp_i;
         end
         default: begin
            bus_rsp_o     = '0;
            bus_rsp_o.err = active;                // Same-cycle error, no slave
         end
      endcase
   end

endmodule

//--- hw/wb_sram_sp.sv
/* Single-port local data memory with byte-select writes
   and a registered one-cycle acknowledge */

`timescale 1ns/1ns

module wb_sram_sp #(
   parameter int LMEM_WORDS = 256
) (
   input  logic              clk,
   input  logic              reset_i,
   input  tile_pkg::wb_req_t req_i,
   output tile_pkg::wb_rsp_t rsp_o
);

   localparam int AW = (LMEM_WORDS > 1) ? $clog2(LMEM_WORDS) : 1;

   logic [tile_pkg::DATA_W-1:0] mem [LMEM_WORDS];
   logic [tile_pkg::DATA_W-1:0] dat_q;
   logic [AW-1:0]               word_idx;
   logic                        ack_q;
   logic                        access;

   // No second response right after an ack
   assign access   = req_i.cyc & req_i.stb & ~ack_q;
   assign word_idx = AW'(req_i.adr[tile_pkg::ADDR_W-1:2] % LMEM_WORDS);  // Word address

   always_ff @(posedge clk) begin
      if (access && req_i.we) begin
         for (int b = 0; b < tile_pkg::SEL_W; b++) begin
            if (req_i.sel[b]) begin
               mem[word_idx][8*b +: 8] <= req_i.dat[8*b +: 8];   // Selected lanes only
            end
         end
      end
      if (access && !req_i.we) begin
         dat_q <= mem[word_idx];
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;                          // One-cycle pulse
      end
   end

   assign rsp_o.dat = dat_q;
   assign rsp_o.ack = ack_q;
   assign rsp_o.err = 1'b0;                        // Every access is legal

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile the tile testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_compute_tile_dm -f sim.f -o tb_compute_tile_dm
./obj_dir/tb_compute_tile_dm

//--- sim.f
hw/tile_pkg.sv
hw/wb_bus_arbiter.sv
hw/wb_bus_decode.sv
hw/wb_sram_sp.sv
hw/bootrom.sv
hw/compute_tile_dm.sv
verification/compute_tile_sva.sv
verification/tb_compute_tile_dm.sv

//--- verification/compute_tile_sva.sv
/* Bus protocol assertions on the tile master ports,
   bound into the tile top level */

`timescale 1ns/1ns

module compute_tile_sva #(
   parameter int NUM_MASTERS = 3
) (
   input logic                                clk,
   input logic                                reset_i,
   input tile_pkg::wb_req_t [NUM_MASTERS-1:0] m_req_i,
   input tile_pkg::wb_rsp_t [NUM_MASTERS-1:0] m_rsp_i
);

   logic [NUM_MASTERS-1:0] rsp_any;               // Ack or err per master

   always_comb begin
      for (int m = 0; m < NUM_MASTERS; m++) begin
         rsp_any[m] = m_rsp_i[m].ack | m_rsp_i[m].err;
      end
   end

   // Only the granted master can be answered
   one_rsp_per_cycle: assert property (
      @(posedge clk) disable iff (reset_i) $onehot0(rsp_any)
   ) else $error("More than one master got a response in the same cycle");

   quiet_in_reset: assert property (
      @(posedge clk) reset_i |=> (rsp_any == '0)
   ) else $error("A response appeared while reset was held");

   for (genvar m = 0; m < NUM_MASTERS; m++) begin : gen_master
      ack_err_excl: assert property (
         @(posedge clk) disable iff (reset_i) !(m_rsp_i[m].ack && m_rsp_i[m].err)
      ) else $error("Master %0d saw ack and err in the same cycle", m);

      // Unmapped error is combinational, so stb must still be up
      rsp_needs_stb: assert property (
         @(posedge clk) disable iff (reset_i) rsp_any[m] |-> m_req_i[m].stb
      ) else $error("Master %0d got a response while its stb was low", m);
   end

endmodule

bind compute_tile_dm compute_tile_sva #(
   .NUM_MASTERS (NUM_MASTERS)
) u_sva (
   .clk     (clk),
   .reset_i (reset_i),
   .m_req_i (m_req_i),
   .m_rsp_i (m_rsp_o)
);

//--- verification/tb_compute_tile_dm.sv
/* Testbench for the compute tile bus: master stimulus, memory model,
   data and response checks, watchdog */

`timescale 1ns/1ns

module tb_compute_tile_dm;

   localparam int NUM_MASTERS = 3;
   localparam int LMEM_WORDS  = 256;
   localparam int N_RAND      = 8;                 // Random write/read pairs
   localparam int N_CONC      = 4;                 // Pairs per master under contention
   localparam int XFER_LIMIT  = 20;                // Cycles a transfer may wait
   localparam logic [15:0] BOOT_TAG_EXP = 16'hb007;
   // Transfers over all phases, sizes the watchdog
   localparam int NUM_TRANS = 2 * N_RAND + 3 * 3 + 16 + 5 + NUM_MASTERS * N_CONC * 2;

   logic                                clk;
   logic                                reset_i;
   tile_pkg::wb_req_t [NUM_MASTERS-1:0] m_req;
   tile_pkg::wb_rsp_t [NUM_MASTERS-1:0] m_rsp;

   logic [31:0] model_mem [LMEM_WORDS];            // Expected memory contents
   logic [31:0] conc_data [NUM_MASTERS][N_CONC];
   int          seed = 32'h43ae_adf7;
   int          resp_total = 0;                    // Responses seen on all masters

   compute_tile_dm #(
      .NUM_MASTERS (NUM_MASTERS),
      .LMEM_WORDS  (LMEM_WORDS)
   ) dut_i (
      .clk     (clk),
      .reset_i (reset_i),
      .m_req_i (m_req),
      .m_rsp_o (m_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic stop_on_failure(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1);
   endtask

   initial begin
      repeat (NUM_TRANS * 20 + 100) @(posedge clk);
      stop_on_failure("Watchdog expired, the bus stopped answering");
   end

   function automatic int responses_now();
      int n;
      n = 0;
      for (int m = 0; m < NUM_MASTERS; m++) begin
         if (m_rsp[m].ack || m_rsp[m].err) begin
            n++;
         end
      end
      return n;
   endfunction

   always @(posedge clk) begin
      resp_total <= resp_total + responses_now();
   end

   function automatic int word_index(input logic [31:0] adr);
      return int'({2'b00, adr[31:2]}) % LMEM_WORDS;    // Wraps at memory depth
   endfunction

   function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  sel);
      logic [31:0] res;
      res = old_w;
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return res;
   endfunction

   // One classic cycle: raise, wait for ack or err, release
   task automatic bus_transfer(input int m, input logic [31:0] adr, input logic [31:0] wdat,
                               input logic [3:0] sel, input logic we, input logic exp_err,
                               output logic [31:0] rdat);
      tile_pkg::wb_req_t req;
      int                start_cnt;
      int                waited;
      req     = '0;
      req.adr = adr;
      req.dat = wdat;
      req.sel = sel;
      req.we  = we;
      req.cyc = 1'b1;
      req.stb = 1'b1;
      @(posedge clk);
      m_req[m] <= req;
      @(negedge clk);
      start_cnt = resp_total;
      waited    = 0;
      while (!(m_rsp[m].ack || m_rsp[m].err)) begin
         waited++;
         if (waited > XFER_LIMIT) begin
            stop_on_failure($sformatf("Master %0d got no response at address %08h", m, adr));
         end
         @(negedge clk);
      end
      assert (m_rsp[m].err == exp_err) else
         stop_on_failure($sformatf("ERROR: m_rsp_o[%0d].err expected %h got %h at %08h",
                                   m, exp_err, m_rsp[m].err, adr));
      // Others served meanwhile, bounded by round robin
      assert (resp_total - start_cnt <= NUM_MASTERS) else
         stop_on_failure($sformatf("Master %0d waited through %0d other transfers",
                                   m, resp_total - start_cnt));
      rdat = m_rsp[m].dat;
      @(posedge clk);
      m_req[m] <= '0;                              // Release in the cycle after the response
      @(negedge clk);
      assert (!m_rsp[m].ack && !m_rsp[m].err) else
         stop_on_failure($sformatf("Master %0d saw a second response for one transfer", m));
   endtask

   task automatic write_word(input int m, input logic [31:0] adr, input logic [31:0] wdat,
                             input logic [3:0] sel);
      logic [31:0] rdat_dummy;
      int          idx;
      idx = word_index(adr);
      bus_transfer(m, adr, wdat, sel, 1'b1, 1'b0, rdat_dummy);
      model_mem[idx] = merge_lanes(model_mem[idx], wdat, sel);
   endtask

   task automatic read_check(input int m, input logic [31:0] adr, input logic [31:0] exp_dat);
      logic [31:0] rdat;
      bus_transfer(m, adr, 32'h0, 4'hf, 1'b0, 1'b0, rdat);
      assert (rdat == exp_dat) else
         stop_on_failure($sformatf("ERROR: m_rsp_o[%0d].dat expected %08h got %08h at %08h",
                                   m, exp_dat, rdat, adr));
   endtask

   task automatic check_idle(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         for (int m = 0; m < NUM_MASTERS; m++) begin
            assert (!m_rsp[m].ack && !m_rsp[m].err) else
               stop_on_failure($sformatf("Master %0d got a response with no request", m));
         end
      end
   endtask

   task automatic random_write_read();
      logic [31:0] adr_list [N_RAND];
      logic [31:0] rnd;
      for (int i = 0; i < N_RAND; i++) begin
         rnd         = $random(seed);
         adr_list[i] = {4'h0, rnd[27:2], 2'b00};      // Region 0, any word
         write_word(0, adr_list[i], $random(seed), 4'hf);
      end
      for (int i = 0; i < N_RAND; i++) begin
         read_check(0, adr_list[i], model_mem[word_index(adr_list[i])]);
      end
   endtask

   task automatic byte_select_check();
      logic [3:0]  sel_list [3];
      logic [31:0] adr;
      sel_list = '{4'b0101, 4'b1000, 4'b0110};
      for (int p = 0; p < 3; p++) begin
         adr = 32'(16 + p) << 2;
         write_word(0, adr, $random(seed), 4'hf);
         write_word(0, adr, $random(seed), sel_list[p]);
         read_check(0, adr, model_mem[word_index(adr)]);
      end
   endtask

   task automatic boot_and_error_check();
      logic [31:0] rdat;
      for (int k = 0; k < 16; k++) begin
         read_check(1, 32'hf000_0000 | (32'(k) << 2), {BOOT_TAG_EXP, 16'(k)});
      end
      bus_transfer(1, 32'hf000_0008, $random(seed), 4'hf, 1'b1, 1'b1, rdat);   // ROM write
      bus_transfer(2, 32'he000_0000, 32'h0, 4'hf, 1'b0, 1'b1, rdat);
      bus_transfer(2, 32'he000_0040, $random(seed), 4'hf, 1'b1, 1'b1, rdat);
      bus_transfer(2, 32'h5000_0010, 32'h0, 4'hf, 1'b0, 1'b1, rdat);
      bus_transfer(2, 32'h5000_0ffc, $random(seed), 4'b0011, 1'b1, 1'b1, rdat);
   endtask

   task automatic master_traffic(input int m, input logic [31:0] base);
      logic [31:0] adr;
      for (int j = 0; j < N_CONC; j++) begin
         adr = base + 32'(j * 4);
         write_word(m, adr, conc_data[m][j], 4'hf);
         read_check(m, adr, conc_data[m][j]);
      end
   endtask

   task automatic concurrent_masters();
      for (int m = 0; m < NUM_MASTERS; m++) begin
         for (int j = 0; j < N_CONC; j++) begin
            conc_data[m][j] = $random(seed);
         end
      end
      fork
         master_traffic(0, 32'h0000_0200);
         master_traffic(1, 32'h0000_0300);
         master_traffic(2, 32'h0000_0380);
      join
   endtask

   initial begin
      m_req   <= '0;
      reset_i <= 1'b1;
      repeat (2) @(posedge clk);
      reset_i <= 1'b0;
      check_idle(5);
      random_write_read();
      byte_select_check();
      boot_and_error_check();
      concurrent_masters();
      check_idle(3);
      $display("Finished with no errors");
      $finish;
   end

endmodule
